//--- hdl/biu_cfg_pkg.sv
// Bus and cache line geometry
// Width constants and the vector types built from them

package biu_cfg_pkg;

    // Byte address and bus word
    localparam int ADDR_WIDTH    = 32;
    localparam int WB_DATA_WIDTH = 16;

    // Line size in bytes
    localparam int DC_LINE_SIZE  = 32;

    // Derived sizes
    localparam int WB_WORD_SIZE   = WB_DATA_WIDTH / 8;
    localparam int LINE_WIDTH     = DC_LINE_SIZE * 8;
    localparam int WORDS_PER_LINE = LINE_WIDTH / WB_DATA_WIDTH;

    // Requester tag
    localparam int TAG_WIDTH     = 4;

    typedef logic [ADDR_WIDTH-1:0]    addr_t;
    typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;
    typedef logic [WB_WORD_SIZE-1:0]  wb_sel_t;
    typedef logic [LINE_WIDTH-1:0]    line_t;
    typedef logic [TAG_WIDTH-1:0]     tag_t;

endpackage

//--- hdl/biu_msg_pkg.sv
// Line request and response records
// Line controller state encoding

package biu_msg_pkg;

    import biu_cfg_pkg::*;

    // One whole-line transfer from the requester
    typedef struct packed {
        tag_t  tag;
        logic  we;
        addr_t addr;    // Line aligned
        line_t wdata;
    } line_req_t;

    // Returned once per request, in request order
    typedef struct packed {
        tag_t  tag;
        logic  we;
        line_t rdata;   // Zero for writes
    } line_rsp_t;

    // Line controller FSM
    typedef enum logic [1:0] {
        CTRL_IDLE  = 2'b00,
        CTRL_ISSUE = 2'b01,
        CTRL_WAIT  = 2'b10
    } ctrl_state_t;

endpackage

//--- hdl/line_req_fifo.sv
// Line request queue
// Circular buffer that hands back one credit per freed entry

`timescale 1ns/1ns

module line_req_fifo #(
    parameter int DEPTH = 4
)(
    input  logic                   i_wb_clk,
    input  logic                   i_wb_rst,
    input  logic                   i_push,
    input  biu_msg_pkg::line_req_t i_req,
    input  logic                   i_pop,
    output logic                   o_valid,
    output biu_msg_pkg::line_req_t o_head,
    output logic                   o_credit
);

    import biu_msg_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    line_req_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_pop   = i_pop && (count != '0);
    // A full queue still takes a push when the head leaves in the same cycle
    assign do_push  = i_push && ((count != FULL_CNT) || do_pop);

    assign o_valid  = (count != '0);
    assign o_head   = mem[rd_ptr];
    assign o_credit = do_pop;

    // Entry storage
    always_ff @(posedge i_wb_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_req;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/ccu_line_ctrl.sv
// Line controller
// Takes queued requests one at a time, runs them through the BIU and returns responses

`timescale 1ns/1ns

module ccu_line_ctrl (
    input  logic                   i_wb_clk,
    input  logic                   i_wb_rst,

    // Request queue
    input  logic                   i_q_valid,
    input  biu_msg_pkg::line_req_t i_q_head,
    output logic                   o_q_pop,

    // Bus interface unit
    output logic                   o_biu_en,
    output logic                   o_biu_we,
    output biu_cfg_pkg::addr_t     o_biu_addr,
    output biu_cfg_pkg::line_t     o_biu_wdata,
    input  logic                   i_biu_done,
    input  biu_cfg_pkg::line_t     i_biu_rdata,

    // Response port
    output logic                   o_rsp_valid,
    output biu_msg_pkg::line_rsp_t o_rsp
);

    import biu_msg_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    line_req_t   req_q;
    logic        done_first;

    // Done is acted on only once, the BIU holds it until enable falls
    assign done_first  = (state_q == CTRL_ISSUE) && i_biu_done;

    assign o_q_pop     = (state_q == CTRL_IDLE) && i_q_valid;
    assign o_biu_en    = (state_q == CTRL_ISSUE);
    assign o_biu_we    = req_q.we;
    assign o_biu_addr  = req_q.addr;
    assign o_biu_wdata = req_q.wdata;

    always_comb begin
        state_d = state_q;
        case (state_q)
            CTRL_IDLE:  if (i_q_valid)  state_d = CTRL_ISSUE;
            CTRL_ISSUE: if (i_biu_done) state_d = CTRL_WAIT;
            // Wait for the BIU to leave its done state before the next line
            CTRL_WAIT:  if (!i_biu_done) state_d = CTRL_IDLE;
            default:    state_d = CTRL_IDLE;
        endcase
    end

    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            state_q     <= CTRL_IDLE;
            o_rsp_valid <= 1'b0;
        end else begin
            state_q     <= state_d;
            o_rsp_valid <= done_first;
        end
    end

    // Request held for the whole transfer
    always_ff @(posedge i_wb_clk) begin
        if (o_q_pop) begin
            req_q <= i_q_head;
        end
    end

    // Response payload
    always_ff @(posedge i_wb_clk) begin
        if (done_first) begin
            o_rsp.tag   <= req_q.tag;
            o_rsp.we    <= req_q.we;
            o_rsp.rdata <= req_q.we ? '0 : i_biu_rdata;
        end
    end

endmodule

//--- hdl/wb_biu.sv
// Wishbone bus interface unit
// Moves one cache line as a burst of pipelined bus words

`timescale 1ns/1ns

module wb_biu #(
    parameter int  ADDR_WIDTH    = biu_cfg_pkg::ADDR_WIDTH,
    parameter int  WB_DATA_WIDTH = biu_cfg_pkg::WB_DATA_WIDTH,
    parameter int  DC_LINE_SIZE  = biu_cfg_pkg::DC_LINE_SIZE,

    localparam int WB_WORD_SIZE  = WB_DATA_WIDTH / 8,
    localparam int LINE_WIDTH    = DC_LINE_SIZE * 8
)(
    // Wishbone master side
    input  logic                     i_wb_clk,
    input  logic                     i_wb_rst,
    input  logic                     i_wb_ack,
    input  logic                     i_wb_stall,
    input  logic [WB_DATA_WIDTH-1:0] i_wb_data,
    output logic                     o_wb_cyc,
    output logic                     o_wb_stb,
    output logic                     o_wb_we,
    output logic [WB_WORD_SIZE-1:0]  o_wb_sel,
    output logic [ADDR_WIDTH-1:0]    o_wb_addr,
    output logic [WB_DATA_WIDTH-1:0] o_wb_data,

    // Line controller side
    input  logic                     i_biu_en,
    input  logic                     i_biu_we,
    input  logic [ADDR_WIDTH-1:0]    i_biu_addr,
    input  logic [LINE_WIDTH-1:0]    i_biu_data,
    output logic [LINE_WIDTH-1:0]    o_biu_data,
    output logic                     o_biu_busy,
    output logic                     o_biu_done
);

    localparam int WORDS = LINE_WIDTH / WB_DATA_WIDTH;
    localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(WORDS - 1);

    typedef enum logic [1:0] {
        BIU_IDLE = 2'b00,
        BIU_REQ  = 2'b01,
        BIU_ACK  = 2'b10,
        BIU_DONE = 2'b11
    } biu_state_t;

    biu_state_t            state_q;
    biu_state_t            state_d;
    logic [IDX_W-1:0]      req_idx;
    logic [IDX_W-1:0]      ack_idx;
    logic [LINE_WIDTH-1:0] rdata_q;
    logic                  active;
    logic                  issue;
    logic                  ack_seen;

    assign active   = (state_q == BIU_REQ) || (state_q == BIU_ACK);
    // A strobe counts only on a cycle without stall
    assign issue    = (state_q == BIU_REQ) && !i_wb_stall;
    assign ack_seen = active && i_wb_ack;

    assign o_wb_cyc   = active;
    assign o_wb_stb   = (state_q == BIU_REQ);
    assign o_wb_we    = i_biu_we;
    assign o_wb_sel   = '1;
    assign o_wb_addr  = i_biu_addr + ADDR_WIDTH'(req_idx) * ADDR_WIDTH'(WB_WORD_SIZE);
    assign o_wb_data  = i_biu_data[req_idx*WB_DATA_WIDTH +: WB_DATA_WIDTH];

    assign o_biu_data = rdata_q;
    assign o_biu_busy = active;
    assign o_biu_done = (state_q == BIU_DONE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            BIU_IDLE: if (i_biu_en) state_d = BIU_REQ;
            BIU_REQ:  if (issue && (req_idx == LAST_IDX)) state_d = BIU_ACK;
            BIU_ACK:  if (ack_seen && (ack_idx == LAST_IDX)) state_d = BIU_DONE;
            BIU_DONE: if (!i_biu_en) state_d = BIU_IDLE;
            default:  state_d = BIU_IDLE;
        endcase
    end

    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            state_q <= BIU_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Issued and acked words are tracked apart, so several stay in flight
    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst || (state_q == BIU_IDLE)) begin
            req_idx <= '0;
            ack_idx <= '0;
        end else begin
            if (issue) begin
                req_idx <= req_idx + 1'b1;
            end
            if (ack_seen) begin
                ack_idx <= ack_idx + 1'b1;
            end
        end
    end

    // Acked read words land in their slot of the line
    always_ff @(posedge i_wb_clk) begin
        if (ack_seen && !i_biu_we) begin
            rdata_q[ack_idx*WB_DATA_WIDTH +: WB_DATA_WIDTH] <= i_wb_data;
        end
    end

endmodule

//--- hdl/wb_sram_slave.sv
// Pipelined Wishbone SRAM slave
// Patterned stall, two-cycle ack with read data

`timescale 1ns/1ns

module wb_sram_slave #(
    parameter int  WB_DATA_WIDTH = biu_cfg_pkg::WB_DATA_WIDTH,
    parameter int  MEM_WORDS     = 1024,

    localparam int SEL_WIDTH     = WB_DATA_WIDTH / 8
)(
    input  logic                     i_wb_clk,
    input  logic                     i_wb_rst,
    input  logic                     i_wb_cyc,
    input  logic                     i_wb_stb,
    input  logic                     i_wb_we,
    input  logic [SEL_WIDTH-1:0]     i_wb_sel,
    input  biu_cfg_pkg::addr_t       i_wb_addr,
    input  logic [WB_DATA_WIDTH-1:0] i_wb_data,
    output logic                     o_wb_ack,
    output logic                     o_wb_stall,
    output logic [WB_DATA_WIDTH-1:0] o_wb_data
);

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int LSB   = $clog2(SEL_WIDTH);

    logic [WB_DATA_WIDTH-1:0] mem [MEM_WORDS];
    logic [1:0]               stall_cnt;
    logic [IDX_W-1:0]         word_idx;
    logic                     accept;
    logic                     ack_s1;
    logic                     ack_s2;
    logic [WB_DATA_WIDTH-1:0] data_s1;
    logic [WB_DATA_WIDTH-1:0] data_s2;

    // Byte address to word index
    assign word_idx   = i_wb_addr[LSB +: IDX_W];
    assign o_wb_stall = (stall_cnt == 2'd2);
    assign accept     = i_wb_cyc && i_wb_stb && !o_wb_stall;
    assign o_wb_ack   = ack_s2;
    assign o_wb_data  = data_s2;

    // Stall on every third cycle
    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            stall_cnt <= '0;
        end else begin
            stall_cnt <= (stall_cnt == 2'd2) ? 2'd0 : stall_cnt + 2'd1;
        end
    end

    // Byte-lane writes on an accepted strobe
    always_ff @(posedge i_wb_clk) begin
        if (accept && i_wb_we) begin
            for (int b = 0; b < SEL_WIDTH; b++) begin
                if (i_wb_sel[b]) begin
                    mem[word_idx][b*8 +: 8] <= i_wb_data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            ack_s1 <= 1'b0;
            ack_s2 <= 1'b0;
        end else begin
            ack_s1 <= accept;
            ack_s2 <= ack_s1;
        end
    end

    // Read data rides along with the ack
    always_ff @(posedge i_wb_clk) begin
        data_s1 <= mem[word_idx];
        data_s2 <= data_s1;
    end

endmodule

//--- hdl/wb_line_top.sv
// Cache line transfer subsystem
// Request queue, line controller, Wishbone BIU and SRAM slave

`timescale 1ns/1ns

module wb_line_top #(
    parameter int FIFO_DEPTH    = 4,
    parameter int ADDR_WIDTH    = biu_cfg_pkg::ADDR_WIDTH,
    parameter int WB_DATA_WIDTH = biu_cfg_pkg::WB_DATA_WIDTH,
    parameter int DC_LINE_SIZE  = biu_cfg_pkg::DC_LINE_SIZE,
    parameter int MEM_WORDS     = 1024
)(
    input  logic                   i_wb_clk,
    input  logic                   i_wb_rst,
    input  logic                   i_req_valid,
    input  biu_msg_pkg::line_req_t i_req,
    output logic                   o_req_credit,
    output logic                   o_rsp_valid,
    output biu_msg_pkg::line_rsp_t o_rsp
);

    import biu_cfg_pkg::*;
    import biu_msg_pkg::*;

    // Queue to controller
    logic      q_valid;
    line_req_t q_head;
    logic      q_pop;

    // Controller to BIU
    logic      biu_en;
    logic      biu_we;
    addr_t     biu_addr;
    line_t     biu_wdata;
    logic      biu_done;
    line_t     biu_rdata;

    // Wishbone bus
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    wb_sel_t   wb_sel;
    addr_t     wb_addr;
    wb_data_t  wb_wdata;
    logic      wb_ack;
    logic      wb_stall;
    wb_data_t  wb_rdata;

    line_req_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_req_fifo (
        .i_wb_clk (i_wb_clk),
        .i_wb_rst (i_wb_rst),
        .i_push   (i_req_valid),
        .i_req    (i_req),
        .i_pop    (q_pop),
        .o_valid  (q_valid),
        .o_head   (q_head),
        .o_credit (o_req_credit)
    );

    ccu_line_ctrl u_line_ctrl (
        .i_wb_clk    (i_wb_clk),
        .i_wb_rst    (i_wb_rst),
        .i_q_valid   (q_valid),
        .i_q_head    (q_head),
        .o_q_pop     (q_pop),
        .o_biu_en    (biu_en),
        .o_biu_we    (biu_we),
        .o_biu_addr  (biu_addr),
        .o_biu_wdata (biu_wdata),
        .i_biu_done  (biu_done),
        .i_biu_rdata (biu_rdata),
        .o_rsp_valid (o_rsp_valid),
        .o_rsp       (o_rsp)
    );

    wb_biu #(
        .ADDR_WIDTH    (ADDR_WIDTH),
        .WB_DATA_WIDTH (WB_DATA_WIDTH),
        .DC_LINE_SIZE  (DC_LINE_SIZE)
    ) u_wb_biu (
        .i_wb_clk   (i_wb_clk),
        .i_wb_rst   (i_wb_rst),
        .i_wb_ack   (wb_ack),
        .i_wb_stall (wb_stall),
        .i_wb_data  (wb_rdata),
        .o_wb_cyc   (wb_cyc),
        .o_wb_stb   (wb_stb),
        .o_wb_we    (wb_we),
        .o_wb_sel   (wb_sel),
        .o_wb_addr  (wb_addr),
        .o_wb_data  (wb_wdata),
        .i_biu_en   (biu_en),
        .i_biu_we   (biu_we),
        .i_biu_addr (biu_addr),
        .i_biu_data (biu_wdata),
        .o_biu_data (biu_rdata),
        .o_biu_busy (),
        .o_biu_done (biu_done)
    );

    wb_sram_slave #(
        .WB_DATA_WIDTH (WB_DATA_WIDTH),
        .MEM_WORDS     (MEM_WORDS)
    ) u_wb_sram (
        .i_wb_clk   (i_wb_clk),
        .i_wb_rst   (i_wb_rst),
        .i_wb_cyc   (wb_cyc),
        .i_wb_stb   (wb_stb),
        .i_wb_we    (wb_we),
        .i_wb_sel   (wb_sel),
        .i_wb_addr  (wb_addr),
        .i_wb_data  (wb_wdata),
        .o_wb_ack   (wb_ack),
        .o_wb_stall (wb_stall),
        .o_wb_data  (wb_rdata)
    );

endmodule

//--- verification/tb_wb_line_top.sv
// Testbench for the cache line transfer subsystem
// Credit-based requester, reference line memory, assertions and test report

`timescale 1ns/1ns

module tb_wb_line_top;

    import biu_cfg_pkg::*;
    import biu_msg_pkg::*;

    localparam int FIFO_DEPTH  = 4;
    localparam int MEM_WORDS   = 1024;
    localparam int NUM_LINES   = MEM_WORDS * WB_WORD_SIZE / DC_LINE_SIZE;
    localparam int TOTAL_REQ   = 16 + 12 + (FIFO_DEPTH + 2) + 3;
    // Per request budget plus reset and margin, in ns
    localparam int WATCHDOG_NS = (TOTAL_REQ * 200 + 10 + 100) * 10;

    logic      i_wb_clk;
    logic      i_wb_rst;
    logic      i_req_valid;
    line_req_t i_req;
    logic      o_req_credit;
    logic      o_rsp_valid;
    line_rsp_t o_rsp;

    int        seed = 32'ha8a9_956f;
    int        credits = FIFO_DEPTH;
    int        credit_pulses = 0;
    int        req_cnt = 0;
    int        rsp_cnt = 0;
    int        errors = 0;
    int        errors_at_start = 0;
    int        tests = 0;
    int        failed = 0;
    logic      saw_zero = 1'b0;
    logic      rst_q = 1'b0;
    string     test_name = "reset_quiet";
    line_t     ref_mem [addr_t];
    addr_t     written [$];
    line_rsp_t exp_rsp [TOTAL_REQ + 1];
    line_rsp_t exp_now;

    wb_line_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .MEM_WORDS  (MEM_WORDS)
    ) u_wb_line_top (
        .i_wb_clk     (i_wb_clk),
        .i_wb_rst     (i_wb_rst),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .o_req_credit (o_req_credit),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp        (o_rsp)
    );

    initial begin
        i_wb_clk = 1'b0;
        forever #5 i_wb_clk = ~i_wb_clk;
    end

    // Next response expected, in request order
    assign exp_now = exp_rsp[rsp_cnt];

    // Requester credit count and response bookkeeping
    always @(posedge i_wb_clk) begin
        rst_q <= i_wb_rst;
        if (i_wb_rst) begin
            credits       <= FIFO_DEPTH;
            credit_pulses <= 0;
            rsp_cnt       <= 0;
        end else begin
            credits <= credits - (i_req_valid ? 1 : 0) + (o_req_credit ? 1 : 0);
            if (o_req_credit) begin
                credit_pulses <= credit_pulses + 1;
            end
            if (o_rsp_valid) begin
                rsp_cnt <= rsp_cnt + 1;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge i_wb_clk)
        rst_q |-> (!o_req_credit && !o_rsp_valid))
        else begin
            errors = errors + 1;
            $display("error reset_quiet: expected credit 0 rsp_valid 0 actual credit %b rsp_valid %b",
                     $sampled(o_req_credit), $sampled(o_rsp_valid));
        end

    // Tag, write flag and line data of every response
    a_rsp_match: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        o_rsp_valid |-> (o_rsp == exp_now))
        else begin
            errors = errors + 1;
            $display("error %s: expected %h actual %h", test_name, $sampled(exp_now),
                     $sampled(o_rsp));
        end

    a_rsp_extra: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        o_rsp_valid |-> (rsp_cnt < req_cnt))
        else begin
            errors = errors + 1;
            $display("%s: a response arrived with no request outstanding", test_name);
        end

    a_credit_range: assert property (@(posedge i_wb_clk) disable iff (i_wb_rst)
        (credits >= 0) && (credits <= FIFO_DEPTH))
        else begin
            errors = errors + 1;
            $display("%s: credit count left its range, now %0d", test_name, credits);
        end

    function automatic addr_t random_addr();
        int unsigned idx;
        idx = $unsigned($random(seed)) % NUM_LINES;
        return addr_t'(idx * DC_LINE_SIZE);
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int i = 0; i < LINE_WIDTH / 32; i++) begin
            l[i*32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    task automatic next_cycle();
        @(posedge i_wb_clk);
        #1;
    endtask

    // Spend one credit and record the response this request must produce
    task automatic send_req(input logic we, input addr_t addr, input line_t wdata);
        line_req_t req;
        line_rsp_t rsp;
        while (credits == 0) begin
            saw_zero = 1'b1;
            next_cycle();
        end
        req.tag   = tag_t'($random(seed));
        req.we    = we;
        req.addr  = addr;
        req.wdata = we ? wdata : '0;
        rsp.tag   = req.tag;
        rsp.we    = we;
        rsp.rdata = we ? '0 : ref_mem[addr];
        if (we) begin
            ref_mem[addr] = wdata;
        end
        exp_rsp[req_cnt] = rsp;
        req_cnt = req_cnt + 1;
        i_req = req;
        i_req_valid = 1'b1;
        next_cycle();
        i_req_valid = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = errors;
    endtask

    // Wait for all responses, then check credit return
    task automatic end_test();
        while (rsp_cnt != req_cnt) begin
            next_cycle();
        end
        assert (credit_pulses == rsp_cnt)
            else begin
                errors = errors + 1;
                $display("error %s: expected %0d credits returned actual %0d",
                         test_name, rsp_cnt, credit_pulses);
            end
        assert (credits == FIFO_DEPTH)
            else begin
                errors = errors + 1;
                $display("error %s: expected %0d credits held actual %0d",
                         test_name, FIFO_DEPTH, credits);
            end
        tests = tests + 1;
        if (errors == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            failed = failed + 1;
            $display("test %s: failed", test_name);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: %0d of %0d responses arrived", rsp_cnt, req_cnt);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        addr_t a;
        line_t l;
        logic  we;
        i_wb_rst    = 1'b1;
        i_req_valid = 1'b0;
        i_req       = '0;
        repeat (10) @(posedge i_wb_clk);
        #1;
        i_wb_rst = 1'b0;
        next_cycle();
        next_cycle();
        end_test();

        begin_test("write_read");
        for (int i = 0; i < 8; i++) begin
            a = random_addr();
            written.push_back(a);
            send_req(1'b1, a, random_line());
        end
        for (int i = 0; i < 8; i++) begin
            send_req(1'b0, written[i], '0);
        end
        end_test();

        begin_test("tag_order");
        for (int i = 0; i < 12; i++) begin
            we = ($random(seed) & 1) != 0;
            a  = we ? random_addr() : written[$unsigned($random(seed)) % written.size()];
            if (we) begin
                written.push_back(a);
            end
            send_req(we, a, random_line());
        end
        end_test();

        // Back to back burst runs the credit count down to zero
        begin_test("credits");
        saw_zero = 1'b0;
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            send_req(i[0] == 1'b0, written[i], random_line());
        end
        assert (saw_zero)
            else begin
                errors = errors + 1;
                $display("credits: the credit count never reached zero during the burst");
            end
        end_test();

        begin_test("overwrite");
        a = random_addr();
        l = random_line();
        send_req(1'b1, a, l);
        send_req(1'b1, a, ~l);
        send_req(1'b0, a, '0);
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if ((errors == 0) && (failed == 0)) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
hdl/biu_cfg_pkg.sv
hdl/biu_msg_pkg.sv
hdl/line_req_fifo.sv
hdl/ccu_line_ctrl.sv
hdl/wb_biu.sv
hdl/wb_sram_slave.sv
hdl/wb_line_top.sv
verification/tb_wb_line_top.sv

//--- run.sh
#!/bin/sh
# Build and run the cache line transfer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_wb_line_top -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_wb_line_top)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "^SIMULATION PASSED$"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
